/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_out_ctrl
FILELIST  = vlog.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run $(TOP) with $(VERILATOR)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(BUILD_DIR)

/* axi_burst_writer.sv */
`timescale 1ns/1ps
`include "out_ctrl_config.svh"

module axi_burst_writer
    import out_ctrl_pkg::*;
(
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     burst_req,
    input  axi_addr_t                burst_addr,
    input  tile_row_t                burst_row,
    output logic                     burst_done,
    output axi_addr_t                m_axi_awaddr,
    output logic                     m_axi_awvalid,
    input  logic                     m_axi_awready,
    output logic [7:0]               m_axi_awlen,
    output axi_word_t                m_axi_wdata,
    output logic [`OC_WORD_W/8-1:0]  m_axi_wstrb,
    output logic                     m_axi_wlast,
    output logic                     m_axi_wvalid,
    input  logic                     m_axi_wready
);

    localparam int                BEAT_W    = $clog2(`OC_BURST_BEATS);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`OC_BURST_BEATS - 1);

    axi_word_t [`OC_BURST_BEATS-1:0] row_words;
    logic [BEAT_W-1:0]               beat;
    logic                            aw_hs;
    logic                            w_hs;

    assign aw_hs = m_axi_awvalid && m_axi_awready;
    assign w_hs  = m_axi_wvalid && m_axi_wready;

    // fixed burst fields
    assign m_axi_awlen = 8'(`OC_BURST_BEATS - 1);
    assign m_axi_wstrb = '1;

    // word k is bits 32k+31:32k of the row
    assign m_axi_wdata = row_words[beat];
    assign m_axi_wlast = m_axi_wvalid && (beat == LAST_BEAT);
    assign burst_done  = w_hs && m_axi_wlast;

    always_ff @(posedge aclk) begin
        if (burst_req) begin
            m_axi_awaddr <= burst_addr;
            row_words    <= burst_row;
        end
    end

    ////////////////////
    // AW then W
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            m_axi_awvalid <= 1'b0;
            m_axi_wvalid  <= 1'b0;
            beat          <= '0;
        end else begin
            if (burst_req) begin
                m_axi_awvalid <= 1'b1;
            end else if (aw_hs) begin
                m_axi_awvalid <= 1'b0;
            end
            if (aw_hs) begin
                m_axi_wvalid <= 1'b1;
                beat         <= '0;
            end else if (w_hs) begin
                if (beat == LAST_BEAT) begin
                    m_axi_wvalid <= 1'b0;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

    a_req_when_idle: assert property (
        @(posedge aclk) disable iff (!aresetn)
        burst_req |-> !m_axi_awvalid && !m_axi_wvalid
    );

    a_aw_hold: assert property (
        @(posedge aclk) disable iff (!aresetn)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr)
    );

    a_w_hold: assert property (
        @(posedge aclk) disable iff (!aresetn)
        m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata)
    );

endmodule

/* out_ctrl_config.svh */
`ifndef OUT_CTRL_CONFIG_SVH
`define OUT_CTRL_CONFIG_SVH

////////////////////
// pixel and tile shape
////////////////////

`define OC_PIX_W        24
`define OC_TILE_DIM     4

////////////////////
// AXI write burst shape
////////////////////

`define OC_WORD_W       32
// one burst carries one tile row of 4 pixels
`define OC_BURST_BEATS  3

////////////////////
// frame geometry and control
////////////////////

`define OC_TILE_COLS    4
`define OC_TILE_ROWS    2
`define OC_PASS_BEATS   16
`define OC_IRQ_CYCLES   4

// byte step from one tile column to the next, 4 pixels of 3 bytes
`define OC_ROW_STEP_BYTES (`OC_TILE_DIM * `OC_PIX_W / 8)
`define OC_LINE_BYTES     (`OC_TILE_COLS * `OC_ROW_STEP_BYTES)

`endif

/* out_ctrl_patterns.txt */
// columns: destination address, then the 24-bit pixel base of tiles 0 to 7
// one frame per line, pixel n of a tile holds base + n
00001000 000000 000100 000200 000300 000400 000500 000600 000700
00020400 fffff8 123456 abcdef 00ff00 7ffff0 800000 0a0a0a 5c5c5c
80000040 c0d0e0 010203 fedcb0 333330 000010 a5a5a0 ffffe8 765430

/* out_ctrl_pkg.sv */
`include "out_ctrl_config.svh"

package out_ctrl_pkg;

    // one pixel as produced by the compute array
    typedef logic [`OC_PIX_W-1:0] pixel_t;

    // pixel n sits at row n/4, column n%4, pixel 0 in the low bits
    typedef pixel_t [`OC_TILE_DIM*`OC_TILE_DIM-1:0] tile_t;

    // four pixels of one tile row, 96 bits
    typedef pixel_t [`OC_TILE_DIM-1:0] tile_row_t;

    typedef logic [`OC_WORD_W-1:0] axi_word_t;
    typedef logic [31:0]           axi_addr_t;

    // tile column and tile row counters
    typedef logic [7:0] tile_cnt_t;

    // frame sequencer states, idle/pass/store also name the capture phases
    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_PASS  = 3'd1,
        S_STORE = 3'd2,
        S_WRITE = 3'd3,
        S_NEXT  = 3'd4
    } seq_state_t;

endpackage

/* out_ctrl_top.sv */
`timescale 1ns/1ps
`include "out_ctrl_config.svh"

module out_ctrl_top
    import out_ctrl_pkg::*;
(
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     start,
    input  axi_addr_t                dst_addr,
    input  tile_t                    result,
    input  logic                     result_valid,
    output logic                     busy,
    output logic                     finish_irq,
    output axi_addr_t                m_axi_awaddr,
    output logic                     m_axi_awvalid,
    input  logic                     m_axi_awready,
    output logic [7:0]               m_axi_awlen,
    output axi_word_t                m_axi_wdata,
    output logic [`OC_WORD_W/8-1:0]  m_axi_wstrb,
    output logic                     m_axi_wlast,
    output logic                     m_axi_wvalid,
    input  logic                     m_axi_wready
);

    // capture to sequencer
    logic      frame_start;
    axi_addr_t frame_addr;
    logic      tile_valid;
    tile_t     tile;
    logic      tile_release;
    logic      frame_done;

    // sequencer to writer
    logic      burst_req;
    axi_addr_t burst_addr;
    tile_row_t burst_row;
    logic      burst_done;

    tile_capture u_capture (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .start        (start),
        .dst_addr     (dst_addr),
        .result       (result),
        .result_valid (result_valid),
        .tile_release (tile_release),
        .frame_done   (frame_done),
        .busy         (busy),
        .frame_start  (frame_start),
        .frame_addr   (frame_addr),
        .tile_valid   (tile_valid),
        .tile         (tile)
    );

    tile_write_seq u_seq (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .frame_start  (frame_start),
        .frame_addr   (frame_addr),
        .tile_valid   (tile_valid),
        .tile         (tile),
        .burst_done   (burst_done),
        .tile_release (tile_release),
        .frame_done   (frame_done),
        .burst_req    (burst_req),
        .burst_addr   (burst_addr),
        .burst_row    (burst_row),
        .finish_irq   (finish_irq)
    );

    axi_burst_writer u_writer (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .burst_req     (burst_req),
        .burst_addr    (burst_addr),
        .burst_row     (burst_row),
        .burst_done    (burst_done),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_awlen   (m_axi_awlen),
        .m_axi_wdata   (m_axi_wdata),
        .m_axi_wstrb   (m_axi_wstrb),
        .m_axi_wlast   (m_axi_wlast),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready)
    );

endmodule

/* tb_out_ctrl.sv */
`timescale 1ns/1ps
`include "out_ctrl_config.svh"

module tb_out_ctrl;

    localparam int TILES      = `OC_TILE_COLS * `OC_TILE_ROWS;
    localparam int FRAMES     = 3;
    localparam int ROWS       = `OC_TILE_DIM;
    localparam int BEATS      = `OC_BURST_BEATS;
    localparam int TILE_W     = `OC_TILE_DIM * `OC_TILE_DIM * `OC_PIX_W;
    localparam int ROW_W      = `OC_TILE_DIM * `OC_PIX_W;
    localparam int MAX_CYCLES = 200 * FRAMES * TILES + 2000;

    logic              aclk = 1'b0;
    logic              aresetn;
    logic              start;
    logic [31:0]       dst_addr;
    logic [TILE_W-1:0] result;
    logic              result_valid;
    logic              busy;
    logic              finish_irq;
    logic [31:0]       m_axi_awaddr;
    logic              m_axi_awvalid;
    logic              m_axi_awready;
    logic [7:0]        m_axi_awlen;
    logic [31:0]       m_axi_wdata;
    logic [3:0]        m_axi_wstrb;
    logic              m_axi_wlast;
    logic              m_axi_wvalid;
    logic              m_axi_wready;

    logic [31:0] pat [FRAMES*(TILES+1)];
    logic [31:0] aw_q [$];
    logic [31:0] w_q [$];
    logic        last_q [$];
    integer      seed = 29;
    logic [31:0] rnd;
    bit          stall_en;
    bit          stall_now;
    bit          irq_prev;
    int          irq_run;
    int          irq_len;
    int          irq_beats;
    int          irq_pulses;
    int          aw_start;
    int          w_start;
    int          errors;
    int          bus_errors;
    int          mark;
    int          cycles;

    out_ctrl_top dut (.*);

    always #2 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // AXI slave ready, random only while a stall test runs
    initial begin
        m_axi_awready = 1'b1;
        m_axi_wready  = 1'b1;
        forever begin
            @(posedge aclk);
            stall_now = stall_en;
            #1;
            rnd = $random(seed);
            m_axi_awready = stall_now ? rnd[0] : 1'b1;
            m_axi_wready  = stall_now ? rnd[1] : 1'b1;
        end
    end

    ////////////////////
    // bus monitor
    ////////////////////

    always @(negedge aclk) begin
        if (aresetn) begin
            // irq first, so a rise on the final beat counts as too early
            if (finish_irq) begin
                if (!irq_prev) begin
                    irq_beats = w_q.size();
                end
                irq_run = irq_run + 1;
            end else if (irq_prev) begin
                irq_len    = irq_run;
                irq_run    = 0;
                irq_pulses = irq_pulses + 1;
            end
            irq_prev = finish_irq;
            if (m_axi_awvalid && m_axi_awready) begin
                aw_q.push_back(m_axi_awaddr);
                if (m_axi_awlen != 8'(BEATS - 1)) begin
                    $display("[FAIL] %0t: awlen is %0d, expected %0d", $time, m_axi_awlen,
                             BEATS - 1);
                    bus_errors = bus_errors + 1;
                end
            end
            if (m_axi_wvalid && m_axi_wready) begin
                w_q.push_back(m_axi_wdata);
                last_q.push_back(m_axi_wlast);
                if (m_axi_wstrb != 4'hf) begin
                    $display("[FAIL] %0t: wstrb is %h, expected f", $time, m_axi_wstrb);
                    bus_errors = bus_errors + 1;
                end
            end
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    function automatic logic [23:0] pixel_of(input logic [31:0] base, input int n);
        return 24'(base + 32'(n));
    endfunction

    function automatic logic [TILE_W-1:0] tile_of(input logic [31:0] base);
        logic [TILE_W-1:0] t;
        int n;
        t = '0;
        for (n = 0; n < `OC_TILE_DIM * `OC_TILE_DIM; n++) begin
            t[`OC_PIX_W*n +: `OC_PIX_W] = pixel_of(base, n);
        end
        return t;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] base, input int r,
                                                  input int k);
        logic [ROW_W-1:0] row;
        int c;
        for (c = 0; c < `OC_TILE_DIM; c++) begin
            row[`OC_PIX_W*c +: `OC_PIX_W] = pixel_of(base, `OC_TILE_DIM * r + c);
        end
        return row[32*k +: 32];
    endfunction

    // tile i sits at column i % cols, tile row i / cols
    function automatic logic [31:0] expected_addr(input logic [31:0] dst, input int i,
                                                  input int r);
        int c;
        int t;
        c = i % `OC_TILE_COLS;
        t = i / `OC_TILE_COLS;
        return dst + 32'((ROWS * t + r) * `OC_LINE_BYTES + `OC_ROW_STEP_BYTES * c);
    endfunction

    ////////////////////
    // stimulus and checks
    ////////////////////

    task automatic put_beat(input logic [TILE_W-1:0] data);
        while (busy) begin
            @(posedge aclk);
            #1;
        end
        result       = data;
        result_valid = 1'b1;
        @(posedge aclk);
        #1;
        result_valid = 1'b0;
    endtask

    task automatic run_frame(input int f, input bit stall);
        int i;
        int pulses;
        aw_start = aw_q.size();
        w_start  = w_q.size();
        pulses   = irq_pulses;
        stall_en = stall;
        dst_addr = pat[f*(TILES+1)];
        start    = 1'b1;
        @(posedge aclk);
        #1;
        start = 1'b0;
        // warm-up beats carry all-ones pixels
        for (i = 0; i < `OC_PASS_BEATS; i++) put_beat('1);
        for (i = 0; i < TILES; i++) put_beat(tile_of(pat[f*(TILES+1)+1+i]));
        while (irq_pulses == pulses) begin
            @(posedge aclk);
            #1;
        end
        stall_en = 1'b0;
    endtask

    task automatic check_first_row(input int f);
        int k;
        if (w_q.size() < w_start + BEATS) begin
            $display("[FAIL] %0t: first burst missing, only %0d data beats seen", $time,
                     w_q.size() - w_start);
            errors++;
        end else begin
            for (k = 0; k < BEATS; k++) begin
                if (w_q[w_start+k] != expected_word(pat[f*(TILES+1)+1], 0, k)) begin
                    $display("[FAIL] %0t: first burst word %0d is %h, expected %h", $time, k,
                             w_q[w_start+k], expected_word(pat[f*(TILES+1)+1], 0, k));
                    errors++;
                end
            end
        end
    endtask

    task automatic check_addresses(input int f);
        int i;
        int r;
        if (aw_q.size() - aw_start != TILES * ROWS) begin
            $display("[FAIL] %0t: %0d bursts written, expected %0d", $time,
                     aw_q.size() - aw_start, TILES * ROWS);
            errors++;
        end else begin
            for (i = 0; i < TILES; i++) begin
                for (r = 0; r < ROWS; r++) begin
                    if (aw_q[aw_start+i*ROWS+r] != expected_addr(pat[f*(TILES+1)], i, r)) begin
                        $display("[FAIL] %0t: tile %0d row %0d address %h, expected %h", $time,
                                 i, r, aw_q[aw_start+i*ROWS+r],
                                 expected_addr(pat[f*(TILES+1)], i, r));
                        errors++;
                    end
                end
            end
        end
    endtask

    task automatic check_data(input int f);
        int i;
        int r;
        int k;
        int idx;
        if (w_q.size() - w_start != TILES * ROWS * BEATS) begin
            $display("[FAIL] %0t: %0d data beats written, expected %0d", $time,
                     w_q.size() - w_start, TILES * ROWS * BEATS);
            errors++;
        end else begin
            for (i = 0; i < TILES; i++) begin
                for (r = 0; r < ROWS; r++) begin
                    for (k = 0; k < BEATS; k++) begin
                        idx = w_start + (i * ROWS + r) * BEATS + k;
                        if (w_q[idx] != expected_word(pat[f*(TILES+1)+1+i], r, k)) begin
                            $display("[FAIL] %0t: tile %0d row %0d word %0d is %h, expected %h",
                                     $time, i, r, k, w_q[idx],
                                     expected_word(pat[f*(TILES+1)+1+i], r, k));
                            errors++;
                        end
                        if (last_q[idx] != (k == BEATS - 1)) begin
                            $display("[FAIL] %0t: tile %0d row %0d word %0d has wlast %b",
                                     $time, i, r, k, last_q[idx]);
                            errors++;
                        end
                    end
                end
            end
        end
    endtask

    task automatic check_finish();
        if (irq_beats - w_start != TILES * ROWS * BEATS) begin
            $display("[FAIL] %0t: finish_irq rose after %0d data beats, expected %0d", $time,
                     irq_beats - w_start, TILES * ROWS * BEATS);
            errors++;
        end
        if (irq_len != `OC_IRQ_CYCLES) begin
            $display("[FAIL] %0t: finish_irq high for %0d cycles, expected %0d", $time,
                     irq_len, `OC_IRQ_CYCLES);
            errors++;
        end
        if (!busy) begin
            $display("[FAIL] %0t: busy is low after the frame, expected high", $time);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name);
        if (errors + bus_errors == mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors + bus_errors - mark);
        end
        mark = errors + bus_errors;
    endtask

    initial begin
        aresetn      = 1'b0;
        start        = 1'b0;
        dst_addr     = '0;
        result       = '0;
        result_valid = 1'b0;
        stall_en     = 1'b0;
        $readmemh("out_ctrl_patterns.txt", pat);
        repeat (8) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        if (m_axi_awvalid || m_axi_wvalid || finish_irq || !busy) begin
            $display("[FAIL] %0t: after reset awvalid=%b wvalid=%b finish_irq=%b busy=%b",
                     $time, m_axi_awvalid, m_axi_wvalid, finish_irq, busy);
            errors++;
        end
        repeat (20) @(posedge aclk);
        #1;
        if (aw_q.size() != 0 || w_q.size() != 0) begin
            $display("[FAIL] %0t: %0d bursts started without a start edge", $time,
                     aw_q.size());
            errors++;
        end
        report_test(1, "reset state");

        run_frame(0, 1'b0);
        check_first_row(0);
        report_test(2, "warm-up discard");
        check_addresses(0);
        report_test(3, "address order");
        check_data(0);
        report_test(4, "data and framing");

        run_frame(1, 1'b1);
        check_first_row(1);
        check_addresses(1);
        check_data(1);
        report_test(5, "back-pressure");

        // second frame at a new address after a finished one
        run_frame(2, 1'b1);
        check_finish();
        check_first_row(2);
        check_addresses(2);
        check_data(2);
        report_test(6, "completion");

        $display("summary: 6 tests, %0d errors", errors + bus_errors);
        if (errors + bus_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tile_capture.sv */
`timescale 1ns/1ps
`include "out_ctrl_config.svh"

module tile_capture
    import out_ctrl_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      start,
    input  axi_addr_t dst_addr,
    input  tile_t     result,
    input  logic      result_valid,
    input  logic      tile_release,
    input  logic      frame_done,
    output logic      busy,
    output logic      frame_start,
    output axi_addr_t frame_addr,
    output logic      tile_valid,
    output tile_t     tile
);

    localparam int PASS_W = $clog2(`OC_PASS_BEATS + 1);

    seq_state_t        phase;
    logic [1:0]        start_q;
    logic [PASS_W-1:0] pass_cnt;
    logic              take;

    ////////////////////
    // start edge
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            start_q <= 2'b00;
        end else begin
            start_q <= {start_q[0], start};
        end
    end

    // only a start edge seen while idle opens a frame
    assign frame_start = (start_q == 2'b01) && (phase == S_IDLE);

    // address latched on the same edge that samples start high
    always_ff @(posedge aclk) begin
        if (phase == S_IDLE && start && !start_q[0]) begin
            frame_addr <= dst_addr;
        end
    end

    ////////////////////
    // phase and warm-up
    ////////////////////

    // accept beats during warm-up, or while the buffer is free
    assign busy = !((phase == S_PASS) || (phase == S_STORE && !tile_valid));
    assign take = result_valid && !busy;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            phase    <= S_IDLE;
            pass_cnt <= '0;
        end else begin
            case (phase)
                S_IDLE: begin
                    if (frame_start) begin
                        phase    <= S_PASS;
                        pass_cnt <= '0;
                    end
                end
                S_PASS: begin
                    if (take) begin
                        pass_cnt <= pass_cnt + 1'b1;
                        if (pass_cnt == PASS_W'(`OC_PASS_BEATS - 1)) begin
                            phase <= S_STORE;
                        end
                    end
                end
                S_STORE: begin
                    if (frame_done) begin
                        phase <= S_IDLE;
                    end
                end
                default: phase <= S_IDLE;
            endcase
        end
    end

    // one-tile buffer
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            tile_valid <= 1'b0;
        end else if (phase == S_STORE && take) begin
            tile_valid <= 1'b1;
        end else if (tile_release) begin
            tile_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (phase == S_STORE && take) begin
            tile <= result;
        end
    end

    // no ready on the result side, the source must watch busy
    a_no_beat_when_busy: assert property (
        @(posedge aclk) disable iff (!aresetn)
        result_valid |-> !busy
    );

endmodule

/* tile_write_seq.sv */
`timescale 1ns/1ps
`include "out_ctrl_config.svh"

module tile_write_seq
    import out_ctrl_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      frame_start,
    input  axi_addr_t frame_addr,
    input  logic      tile_valid,
    input  tile_t     tile,
    input  logic      burst_done,
    output logic      tile_release,
    output logic      frame_done,
    output logic      burst_req,
    output axi_addr_t burst_addr,
    output tile_row_t burst_row,
    output logic      finish_irq
);

    localparam int        ROW_W      = $clog2(`OC_TILE_DIM);
    localparam int        IRQ_W      = $clog2(`OC_IRQ_CYCLES + 1);
    localparam tile_cnt_t LAST_COL   = tile_cnt_t'(`OC_TILE_COLS - 1);
    localparam tile_cnt_t LAST_ROW   = tile_cnt_t'(`OC_TILE_ROWS - 1);
    localparam axi_addr_t LINE_BYTES = axi_addr_t'(`OC_LINE_BYTES);
    localparam axi_addr_t STEP_BYTES = axi_addr_t'(`OC_ROW_STEP_BYTES);
    localparam axi_addr_t BAND_BYTES = axi_addr_t'(`OC_TILE_DIM * `OC_LINE_BYTES);

    seq_state_t                   state;
    seq_state_t                   state_nxt;
    tile_cnt_t                    col_cnt;
    tile_cnt_t                    row_cnt;
    logic [ROW_W-1:0]             row_idx;
    logic [IRQ_W-1:0]             irq_cnt;
    axi_addr_t                    band_addr;
    axi_addr_t                    tile_addr;
    tile_row_t [`OC_TILE_DIM-1:0] tile_rows;
    logic                         tile_ready;
    logic                         row_step;
    logic                         last_row;
    logic                         last_tile;

    assign tile_rows  = tile;
    assign tile_ready = (state == S_PASS || state == S_STORE) && tile_valid;
    assign last_row   = (row_idx == ROW_W'(`OC_TILE_DIM - 1));
    assign row_step   = (state == S_WRITE) && burst_done && !last_row;
    assign last_tile  = (col_cnt == LAST_COL) && (row_cnt == LAST_ROW);

    assign tile_release = (state == S_NEXT);
    assign frame_done   = (state == S_NEXT) && last_tile;

    ////////////////////
    // frame FSM
    ////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:          if (frame_start) state_nxt = S_PASS;
            S_PASS, S_STORE: if (tile_valid) state_nxt = S_WRITE;
            S_WRITE:         if (burst_done && last_row) state_nxt = S_NEXT;
            S_NEXT:          state_nxt = last_tile ? S_IDLE : S_STORE;
            default:         state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= S_IDLE;
            burst_req <= 1'b0;
            row_idx   <= '0;
            col_cnt   <= '0;
            row_cnt   <= '0;
        end else begin
            state     <= state_nxt;
            burst_req <= tile_ready || row_step;
            if (tile_ready) begin
                row_idx <= '0;
            end else if (row_step) begin
                row_idx <= row_idx + 1'b1;
            end
            if (state == S_IDLE && frame_start) begin
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (state == S_NEXT) begin
                // tiles go left to right, then down one tile row
                if (col_cnt == LAST_COL) begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // addresses and row data
    ////////////////////

    always_ff @(posedge aclk) begin
        if (state == S_IDLE && frame_start) begin
            band_addr <= frame_addr;
            tile_addr <= frame_addr;
        end else if (state == S_NEXT) begin
            if (col_cnt == LAST_COL) begin
                band_addr <= band_addr + BAND_BYTES;
                tile_addr <= band_addr + BAND_BYTES;
            end else begin
                tile_addr <= tile_addr + STEP_BYTES;
            end
        end
        if (tile_ready) begin
            burst_addr <= tile_addr;
            burst_row  <= tile_rows[0];
        end else if (row_step) begin
            // next pixel line of the same tile
            burst_addr <= burst_addr + LINE_BYTES;
            burst_row  <= tile_rows[row_idx + 1'b1];
        end
    end

    // finish pulse, starts on the edge that leaves the last tile
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            finish_irq <= 1'b0;
            irq_cnt    <= '0;
        end else if (frame_done) begin
            finish_irq <= 1'b1;
            irq_cnt    <= IRQ_W'(`OC_IRQ_CYCLES - 1);
        end else if (finish_irq) begin
            if (irq_cnt == '0) begin
                finish_irq <= 1'b0;
            end else begin
                irq_cnt <= irq_cnt - 1'b1;
            end
        end
    end

    // the writer holds a single burst at a time
    a_one_burst: assert property (
        @(posedge aclk) disable iff (!aresetn)
        burst_req |=> (!burst_req until burst_done)
    );

endmodule

/* vlog.f */
+incdir+.
out_ctrl_pkg.sv
tile_capture.sv
tile_write_seq.sv
axi_burst_writer.sv
out_ctrl_top.sv
tb_out_ctrl.sv
